// ==== compile.f ====
+incdir+rtl
rtl/cf_pkg.sv
rtl/branch_jump.sv
rtl/trap_csr.sv
rtl/pc_redirect.sv
rtl/cf_unit.sv
tests/tb_clk_gen.sv
tests/cf_unit_chk.sv
tests/cf_unit_tb.sv

// ==== rtl/branch_jump.sv ====
`include "cf_consts.svh"

module branch_jump (
   input  logic                instr_valid_i,
   input  cf_pkg::word_t       rs1_i,
   input  cf_pkg::word_t       rs2_i,
   input  logic                is_mret_i,
   input  cf_pkg::bj_op_t      branch_jump_op_i,
   input  logic                has_exception_i,
   input  logic                jump_to_exception_i,
   input  cf_pkg::funct3_t     funct3_i,
   output logic                branching_o,
   output cf_pkg::target_sel_e target_sel_o
);

   logic is_eq;
   logic is_lt;
   logic is_ltu;
   logic is_branch;
   logic is_jump;
   logic is_mret;
   logic condition;

   // Operand compares
   assign is_eq  = (rs1_i == rs2_i);
   assign is_lt  = ($signed(rs1_i) < $signed(rs2_i));
   assign is_ltu = (rs1_i < rs2_i);

   // Operation class, only for a valid non-faulting instruction
   assign is_branch = instr_valid_i && !has_exception_i && branch_jump_op_i[1];
   assign is_jump   = instr_valid_i && !has_exception_i && branch_jump_op_i[0];
   assign is_mret   = instr_valid_i && !has_exception_i && is_mret_i;

   always_comb begin
      case (funct3_i)
         `CF_F3_BEQ:  condition = is_eq;
         `CF_F3_BNE:  condition = !is_eq;
         `CF_F3_BLT:  condition = is_lt;
         `CF_F3_BGE:  condition = !is_lt;
         `CF_F3_BLTU: condition = is_ltu;
         `CF_F3_BGEU: condition = !is_ltu;
         // Undefined code is not taken
         default:     condition = 1'b0;
      endcase
   end

   // A pending trap forces the redirect whatever is presented
   assign branching_o = jump_to_exception_i || is_jump || is_mret || (is_branch && condition);

   // Trap beats mret beats ALU target
   always_comb begin
      if (jump_to_exception_i) begin
         target_sel_o = cf_pkg::TGT_MTVEC;
      end else if (is_mret) begin
         target_sel_o = cf_pkg::TGT_MEPC;
      end else begin
         target_sel_o = cf_pkg::TGT_ALU;
      end
   end

endmodule

// ==== rtl/cf_consts.svh ====
`ifndef CF_CONSTS_SVH
`define CF_CONSTS_SVH

// Values after reset
`define CF_RESET_PC     32'h0000_0000
`define CF_MTVEC_RESET  32'h0000_0100

// Machine trap CSR addresses
`define CF_CSR_MTVEC    12'h305
`define CF_CSR_MEPC     12'h341
`define CF_CSR_MCAUSE   12'h342

// Conditional branch funct3 codes
`define CF_F3_BEQ       3'b000
`define CF_F3_BNE       3'b001
`define CF_F3_BLT       3'b100
`define CF_F3_BGE       3'b101
`define CF_F3_BLTU      3'b110
`define CF_F3_BGEU      3'b111

// Redirect target select codes
`define CF_TGT_ALU      2'b00
`define CF_TGT_MTVEC    2'b01
`define CF_TGT_MEPC     2'b10

`endif

// ==== rtl/cf_pkg.sv ====
`include "cf_consts.svh"

package cf_pkg;

   // Data word, also used for PC and CSR contents
   typedef logic [31:0] word_t;

   typedef logic [11:0] csr_addr_t;

   // Branch compare selector
   typedef logic [2:0]  funct3_t;

   // Bit 1 marks a conditional branch, bit 0 a jump
   typedef logic [1:0]  bj_op_t;

   // Exception cause, zero-extended into mcause
   typedef logic [3:0]  cause_t;

   // Source of the redirect target
   typedef enum logic [1:0] {
      TGT_ALU   = `CF_TGT_ALU,
      TGT_MTVEC = `CF_TGT_MTVEC,
      TGT_MEPC  = `CF_TGT_MEPC
   } target_sel_e;

endpackage

// ==== rtl/cf_unit.sv ====
module cf_unit (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              instr_valid_i,
   input  cf_pkg::bj_op_t    branch_jump_op_i,
   input  cf_pkg::funct3_t   funct3_i,
   input  cf_pkg::word_t     rs1_i,
   input  cf_pkg::word_t     rs2_i,
   input  cf_pkg::word_t     alu_target_i,
   input  logic              is_mret_i,
   input  logic              exc_i,
   input  cf_pkg::cause_t    exc_cause_i,
   input  logic              csr_we_i,
   input  cf_pkg::csr_addr_t csr_addr_i,
   input  cf_pkg::word_t     csr_wdata_i,
   output cf_pkg::word_t     csr_rdata_o,
   output cf_pkg::word_t     pc_o,
   output logic              redirect_o
);

   logic                trap_pending;
   logic                branching;
   cf_pkg::target_sel_e target_sel;
   cf_pkg::word_t       mtvec;
   cf_pkg::word_t       mepc;
   cf_pkg::word_t       pc;

   // Branch and jump resolution
   branch_jump i_branch_jump (
      .instr_valid_i       (instr_valid_i),
      .rs1_i               (rs1_i),
      .rs2_i               (rs2_i),
      .is_mret_i           (is_mret_i),
      .branch_jump_op_i    (branch_jump_op_i),
      .has_exception_i     (exc_i),
      .jump_to_exception_i (trap_pending),
      .funct3_i            (funct3_i),
      .branching_o         (branching),
      .target_sel_o        (target_sel)
   );

   // Machine trap registers
   trap_csr i_trap_csr (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .instr_valid_i  (instr_valid_i),
      .exc_i          (exc_i),
      .exc_cause_i    (exc_cause_i),
      .pc_i           (pc),
      .csr_we_i       (csr_we_i),
      .csr_addr_i     (csr_addr_i),
      .csr_wdata_i    (csr_wdata_i),
      .csr_rdata_o    (csr_rdata_o),
      .mtvec_o        (mtvec),
      .mepc_o         (mepc),
      .trap_pending_o (trap_pending)
   );

   pc_redirect i_pc_redirect (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .instr_valid_i  (instr_valid_i),
      .exc_i          (exc_i),
      .trap_pending_i (trap_pending),
      .branching_i    (branching),
      .target_sel_i   (target_sel),
      .alu_target_i   (alu_target_i),
      .mtvec_i        (mtvec),
      .mepc_i         (mepc),
      .pc_o           (pc)
   );

   assign pc_o       = pc;
   assign redirect_o = branching;

endmodule

// ==== rtl/pc_redirect.sv ====
`include "cf_consts.svh"

module pc_redirect (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                instr_valid_i,
   input  logic                exc_i,
   input  logic                trap_pending_i,
   input  logic                branching_i,
   input  cf_pkg::target_sel_e target_sel_i,
   input  cf_pkg::word_t       alu_target_i,
   input  cf_pkg::word_t       mtvec_i,
   input  cf_pkg::word_t       mepc_i,
   output cf_pkg::word_t       pc_o
);

   cf_pkg::word_t pc_q;
   cf_pkg::word_t pc_next;
   cf_pkg::word_t target;
   logic          advance;

   // Redirect target mux
   always_comb begin
      case (target_sel_i)
         cf_pkg::TGT_MTVEC: target = mtvec_i;
         cf_pkg::TGT_MEPC:  target = mepc_i;
         default:           target = alu_target_i;
      endcase
   end

   // Sequential step for a clean instruction outside a trap
   assign advance = instr_valid_i && !exc_i && !trap_pending_i;

   always_comb begin
      if (branching_i) begin
         pc_next = target;
      end else if (advance) begin
         pc_next = pc_q + 32'd4;
      end else begin
         // Idle or faulting instruction
         pc_next = pc_q;
      end
   end

   ////////////////////
   // PC register
   ////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pc_q <= `CF_RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   assign pc_o = pc_q;

endmodule

// ==== rtl/trap_csr.sv ====
`include "cf_consts.svh"

module trap_csr (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              instr_valid_i,
   input  logic              exc_i,
   input  cf_pkg::cause_t    exc_cause_i,
   input  cf_pkg::word_t     pc_i,
   input  logic              csr_we_i,
   input  cf_pkg::csr_addr_t csr_addr_i,
   input  cf_pkg::word_t     csr_wdata_i,
   output cf_pkg::word_t     csr_rdata_o,
   output cf_pkg::word_t     mtvec_o,
   output cf_pkg::word_t     mepc_o,
   output logic              trap_pending_o
);

   cf_pkg::word_t mtvec_q;
   cf_pkg::word_t mepc_q;
   cf_pkg::word_t mcause_q;
   logic          trap_pending_q;

   logic          sel_mtvec;
   logic          sel_mepc;
   logic          sel_mcause;
   logic          trap_take;
   cf_pkg::word_t cause_ext;

   assign sel_mtvec  = (csr_addr_i == `CF_CSR_MTVEC);
   assign sel_mepc   = (csr_addr_i == `CF_CSR_MEPC);
   assign sel_mcause = (csr_addr_i == `CF_CSR_MCAUSE);

   // Faulting instruction, ignored while a trap is already in flight
   assign trap_take = instr_valid_i && exc_i && !trap_pending_q;
   assign cause_ext = {28'd0, exc_cause_i};

   ////////////////////
   // Trap sequencing
   ////////////////////

   // Pending flag lives for one cycle only
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         trap_pending_q <= 1'b0;
      end else begin
         trap_pending_q <= trap_take;
      end
   end

   ////////////////////
   // CSR registers
   ////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mtvec_q <= `CF_MTVEC_RESET;
      end else if (csr_we_i && sel_mtvec) begin
         mtvec_q <= csr_wdata_i;
      end
   end

   // Trap capture wins over a software write in the same cycle
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mepc_q   <= '0;
         mcause_q <= '0;
      end else if (trap_take) begin
         mepc_q   <= pc_i;
         mcause_q <= cause_ext;
      end else if (csr_we_i) begin
         if (sel_mepc) begin
            mepc_q <= csr_wdata_i;
         end
         if (sel_mcause) begin
            mcause_q <= csr_wdata_i;
         end
      end
   end

   // Unknown address reads as zero
   assign csr_rdata_o = sel_mtvec  ? mtvec_q  :
                        sel_mepc   ? mepc_q   :
                        sel_mcause ? mcause_q : '0;

   assign mtvec_o        = mtvec_q;
   assign mepc_o         = mepc_q;
   assign trap_pending_o = trap_pending_q;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps -f compile.f \
   --top-module cf_unit_tb -o cf_unit_sim

# Simulator output goes to the log that holds the verdict
./obj_dir/cf_unit_sim > sim.log 2>&1 || true
cat sim.log

grep -qx "test passed" sim.log

// ==== tests/cf_unit_chk.sv ====
module cf_unit_chk (
   input logic          clk_i,
   input logic          arst_n_i,
   input logic          exc_i,
   input logic          trap_pending_i,
   input logic          redirect_i,
   input cf_pkg::word_t pc_i,
   input cf_pkg::word_t mtvec_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // Pending flag is a single-cycle pulse
   pending_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      trap_pending_i |=> !trap_pending_i)
      else $error("trap_pending high for two cycles");

   // A faulting instruction never redirects by itself
   no_redirect_on_fault: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (exc_i && !trap_pending_i) |-> !redirect_i)
      else $error("redirect_o high for a faulting instruction");

   // PC lands on the trap vector right after the pending cycle
   pc_at_mtvec: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      trap_pending_i |=> (pc_i == $past(mtvec_i)))
      else $error("pc_o not at mtvec after trap entry");

endmodule

// ==== tests/cf_unit_tb.sv ====
`include "cf_consts.svh"

module cf_unit_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // Named as the DUT ports for the .* hookup
   logic              clk_i;
   logic              arst_n_i;
   logic              instr_valid_i;
   cf_pkg::bj_op_t    branch_jump_op_i;
   cf_pkg::funct3_t   funct3_i;
   cf_pkg::word_t     rs1_i;
   cf_pkg::word_t     rs2_i;
   cf_pkg::word_t     alu_target_i;
   logic              is_mret_i;
   logic              exc_i;
   cf_pkg::cause_t    exc_cause_i;
   logic              csr_we_i;
   cf_pkg::csr_addr_t csr_addr_i;
   cf_pkg::word_t     csr_wdata_i;
   cf_pkg::word_t     csr_rdata_o;
   cf_pkg::word_t     pc_o;
   logic              redirect_o;
   integer            seed;
   int                err_cnt;
   int                tests_ok;
   int                tests_bad;
   // Expected PC, stepped by the tests
   cf_pkg::word_t     pc_model;

   tb_clk_gen i_clk_gen (.clk_o(clk_i));

   cf_unit i_cf_unit (.*);

   bind cf_unit cf_unit_chk i_cf_unit_chk (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .exc_i          (exc_i),
      .trap_pending_i (trap_pending),
      .redirect_i     (redirect_o),
      .pc_i           (pc_o),
      .mtvec_i        (mtvec)
   );

   ////////////////////
   // Helpers
   ////////////////////

   task automatic next_edge();
      @(posedge clk_i);
      #1;
   endtask

   task automatic drive(input logic valid, input cf_pkg::bj_op_t op, input cf_pkg::word_t a,
                        input cf_pkg::word_t b, input cf_pkg::word_t target,
                        input logic mret, input logic fault, input cf_pkg::cause_t cause);
      instr_valid_i    = valid;
      branch_jump_op_i = op;
      rs1_i            = a;
      rs2_i            = b;
      alu_target_i     = target;
      is_mret_i        = mret;
      exc_i            = fault;
      exc_cause_i      = cause;
   endtask

   task automatic go_idle();
      drive(1'b0, 2'b00, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0, 4'd0);
   endtask

   // Write lands on the next edge
   task automatic csr_write(input cf_pkg::csr_addr_t addr, input cf_pkg::word_t data);
      csr_we_i    = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      next_edge();
      csr_we_i = 1'b0;
   endtask

   // Read data is combinational, the task returns after the next edge
   task automatic csr_read(input cf_pkg::csr_addr_t addr, output cf_pkg::word_t data);
      csr_addr_i = addr;
      #1;
      data = csr_rdata_o;
      next_edge();
   endtask

   task automatic check_word(input string test, input string what,
                             input cf_pkg::word_t expected, input cf_pkg::word_t actual);
      if (actual !== expected) begin
         $display("Error: %s %s expected %h actual %h", test, what, expected, actual);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name, input int start_err);
      if (err_cnt == start_err) tests_ok++;
      else tests_bad++;
      $display("%s: %0d errors", name, err_cnt - start_err);
   endtask

   // Branch rule straight from the ISA compares
   function automatic logic branch_taken(input cf_pkg::funct3_t f3, input cf_pkg::word_t a,
                                         input cf_pkg::word_t b);
      case (f3)
         `CF_F3_BEQ:  return a == b;
         `CF_F3_BNE:  return a != b;
         `CF_F3_BLT:  return $signed(a) < $signed(b);
         `CF_F3_BGE:  return $signed(a) >= $signed(b);
         `CF_F3_BLTU: return a < b;
         `CF_F3_BGEU: return a >= b;
         default:     return 1'b0;
      endcase
   endfunction

   ////////////////////
   // Tests
   ////////////////////

   task automatic test_reset_values();
      int            start_err;
      cf_pkg::word_t rd;
      start_err = err_cnt;
      pc_model  = `CF_RESET_PC;
      check_word("reset", "pc_o", pc_model, pc_o);
      check_word("reset", "redirect_o", 32'd0, {31'd0, redirect_o});
      csr_read(`CF_CSR_MTVEC, rd);
      check_word("reset", "mtvec", `CF_MTVEC_RESET, rd);
      csr_read(`CF_CSR_MEPC, rd);
      check_word("reset", "mepc", 32'd0, rd);
      csr_read(`CF_CSR_MCAUSE, rd);
      check_word("reset", "mcause", 32'd0, rd);
      finish_test("reset", start_err);
   endtask

   // All funct3 codes, the two undefined ones included
   task automatic test_branches();
      int            start_err;
      cf_pkg::word_t a;
      cf_pkg::word_t b;
      cf_pkg::word_t target;
      cf_pkg::word_t pc_exp;
      logic          taken;
      start_err = err_cnt;
      for (int i = 0; i < 40; i++) begin
         a = $random(seed);
         b = $random(seed);
         // Every fourth pair is equal
         if (i % 4 == 0) b = a;
         for (int k = 0; k < 8; k++) begin
            target   = $random(seed) & 32'hffff_fffc;
            taken    = branch_taken(k[2:0], a, b);
            pc_exp   = taken ? target : pc_model + 32'd4;
            funct3_i = k[2:0];
            drive(1'b1, 2'b10, a, b, target, 1'b0, 1'b0, 4'd0);
            #1;
            check_word("branch", "redirect_o", {31'd0, taken}, {31'd0, redirect_o});
            next_edge();
            check_word("branch", "pc_o", pc_exp, pc_o);
            pc_model = pc_exp;
         end
      end
      go_idle();
      finish_test("branch", start_err);
   endtask

   // Each jump is followed by an idle cycle with a jump left on the bus
   task automatic test_jumps();
      int            start_err;
      cf_pkg::word_t target;
      start_err = err_cnt;
      for (int i = 0; i < 8; i++) begin
         target   = $random(seed) & 32'hffff_fffc;
         funct3_i = i[2:0];
         drive(1'b1, 2'b01, $random(seed), $random(seed), target, 1'b0, 1'b0, 4'd0);
         #1;
         check_word("jump", "redirect_o", 32'd1, {31'd0, redirect_o});
         next_edge();
         pc_model = target;
         check_word("jump", "pc_o", pc_model, pc_o);
         drive(1'b0, 2'b01, 32'd0, 32'd0, $random(seed), 1'b0, 1'b0, 4'd0);
         #1;
         check_word("jump", "idle redirect_o", 32'd0, {31'd0, redirect_o});
         next_edge();
         check_word("jump", "idle pc_o", pc_model, pc_o);
      end
      go_idle();
      finish_test("jump", start_err);
   endtask

   task automatic test_trap();
      int            start_err;
      cf_pkg::word_t fault_pc;
      cf_pkg::word_t rd;
      start_err = err_cnt;
      csr_write(`CF_CSR_MTVEC, 32'h0000_0a40);
      fault_pc = pc_model;
      // Taken branch that also faults
      funct3_i = `CF_F3_BEQ;
      drive(1'b1, 2'b10, 32'h55, 32'h55, 32'h0000_0c00, 1'b0, 1'b1, 4'd7);
      #1;
      check_word("trap", "fault redirect_o", 32'd0, {31'd0, redirect_o});
      next_edge();
      check_word("trap", "held pc_o", fault_pc, pc_o);
      // Faulting jump in the pending cycle, to be ignored
      drive(1'b1, 2'b01, 32'd0, 32'd0, 32'h0000_0f00, 1'b0, 1'b1, 4'd3);
      #1;
      check_word("trap", "pending redirect_o", 32'd1, {31'd0, redirect_o});
      next_edge();
      go_idle();
      pc_model = 32'h0000_0a40;
      check_word("trap", "pc_o", pc_model, pc_o);
      #1;
      check_word("trap", "late redirect_o", 32'd0, {31'd0, redirect_o});
      next_edge();
      csr_read(`CF_CSR_MEPC, rd);
      check_word("trap", "mepc", fault_pc, rd);
      csr_read(`CF_CSR_MCAUSE, rd);
      check_word("trap", "mcause", 32'd7, rd);
      finish_test("trap", start_err);
   endtask

   task automatic test_mret();
      int            start_err;
      cf_pkg::word_t epc;
      start_err = err_cnt;
      epc = $random(seed) & 32'hffff_fffc;
      csr_write(`CF_CSR_MEPC, epc);
      drive(1'b1, 2'b00, 32'd0, 32'd0, epc ^ 32'h0000_1000, 1'b1, 1'b0, 4'd0);
      #1;
      check_word("mret", "redirect_o", 32'd1, {31'd0, redirect_o});
      next_edge();
      go_idle();
      pc_model = epc;
      check_word("mret", "pc_o", pc_model, pc_o);
      finish_test("mret", start_err);
   endtask

   initial begin
      seed        = 32'h5dcd;
      err_cnt     = 0;
      tests_ok    = 0;
      tests_bad   = 0;
      pc_model    = `CF_RESET_PC;
      arst_n_i    = 1'b0;
      funct3_i    = 3'b000;
      csr_we_i    = 1'b0;
      csr_addr_i  = 12'h000;
      csr_wdata_i = 32'd0;
      go_idle();
      repeat (8) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      test_reset_values();
      test_branches();
      test_jumps();
      test_trap();
      test_mret();
      $display("%0d tests ok, %0d tests failing, %0d check errors",
               tests_ok, tests_bad, err_cnt);
      if (err_cnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Watchdog for a stuck run
   initial begin
      #200000;
      $display("Simulation did not finish within 200 us");
      $display("test failed");
      $finish;
   end

endmodule

// ==== tests/tb_clk_gen.sv ====
module tb_clk_gen (
   output logic clk_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // 8 ns period
   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

endmodule
